/* source/lsu_pkg.sv */
/*
  Shared widths, types and transfer attributes of the load/store unit.
  Only 32-bit data and addresses are supported.
  The outstanding-transfer limit is a parameter of the top level and is not set here.
*/

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data and address width
  parameter int unsigned XLEN = 32;

  // Byte lanes per word
  parameter int unsigned BE_W = XLEN / 8;

  typedef logic [XLEN-1:0] data_t;
  typedef logic [BE_W-1:0] be_t;

  // Byte offset inside one word
  typedef logic [1:0]      offset_t;

  ////////////////////////////////////////////////////////////
  // Access size and transfer attributes
  ////////////////////////////////////////////////////////////

  // Size code as seen from the execute stage
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Attributes kept per bus transfer until its response
  typedef struct packed {
    lsu_size_e size;    // Size of the whole access
    logic      sext;    // Sign-extend a load result
    logic      we;      // Store when set
    offset_t   offset;  // Byte offset of the original address
    logic      last;    // Low only for the first half of a split access
  } lsu_txn_t;

endpackage

/* source/lsu_txn_if.sv */
/*
  Carries the attributes of each granted transfer into the transfer queue.
  push is a one-cycle strobe per grant and is only raised while full is low.
*/

`timescale 1ns/100ps

interface lsu_txn_if;

  import lsu_pkg::*;

  // One strobe per granted bus transfer
  logic     push;
  // Attributes of that transfer
  lsu_txn_t txn;
  // Queue is at capacity
  logic     full;

  // Request side
  modport source (output push, output txn, input full);

  // Queue side
  modport sink (input push, input txn, output full);

endinterface

/* source/lsu_request_gen.sv */
/*
  Address generation and bus request drive.
  ex inputs must be held until ex_ready_o is seen at a rising edge.
  A word at a nonzero offset, or a halfword at offset 3, is split into two transfers.
  data_req_o follows ex_valid_i combinationally while the queue is not full.
*/

`timescale 1ns/100ps

module lsu_request_gen (
  input  logic              clk,
  input  logic              rst_n,
  // Execute stage
  input  logic              ex_valid_i,
  output logic              ex_ready_o,
  input  lsu_pkg::data_t    ex_operand_a_i,
  input  lsu_pkg::data_t    ex_operand_b_i,
  input  lsu_pkg::data_t    ex_wdata_i,
  input  logic              ex_we_i,
  input  logic              ex_sext_i,
  input  lsu_pkg::lsu_size_e ex_size_i,
  // Bus request
  output logic              data_req_o,
  input  logic              data_gnt_i,
  output logic              data_we_o,
  output lsu_pkg::data_t    data_addr_o,
  output lsu_pkg::be_t      data_be_o,
  output lsu_pkg::data_t    data_wdata_o,
  // Accepted transfers
  lsu_txn_if.source         txn
);

  import lsu_pkg::*;

  data_t        addr;
  offset_t      offset;
  logic         is_split;
  logic         first_of_split;
  logic         gnt;
  logic [63:0]  wdata_pair;

  // Second address phase of a split access in progress
  logic         split_q;

  ////////////////////////////////////////////////////////////
  // Address and split detection
  ////////////////////////////////////////////////////////////

  assign addr   = ex_operand_a_i + ex_operand_b_i;
  assign offset = addr[1:0];

  // Access crosses a word boundary
  assign is_split = ((ex_size_i == LSU_WORD) && (offset != 2'b00)) ||
                    ((ex_size_i == LSU_HALF) && (offset == 2'b11));

  // First phase of a split access
  assign first_of_split = is_split && !split_q;

  // Back-pressure only from the transfer queue
  assign data_req_o = ex_valid_i && !txn.full;
  assign gnt        = data_req_o && data_gnt_i;

  // Held low over the first grant of a split access
  assign ex_ready_o = gnt && !first_of_split;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!ex_valid_i) begin
      // Dropped access leaves no half-done split behind
      split_q <= 1'b0;
    end else if (gnt) begin
      split_q <= first_of_split;
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (!split_q) begin
      // Lanes past 3 fall off the 4-bit shift
      case (ex_size_i)
        LSU_BYTE: data_be_o = be_t'(4'b0001) << offset;
        LSU_HALF: data_be_o = be_t'(4'b0011) << offset;
        default:  data_be_o = be_t'(4'b1111) << offset;
      endcase
    end else begin
      // Remaining low lanes of the next word
      case (ex_size_i)
        LSU_HALF: data_be_o = be_t'(4'b0001);
        default:  data_be_o = ~(be_t'(4'b1111) << offset);
      endcase
    end
  end

  // Second phase goes to the next aligned word
  assign data_addr_o = split_q ? ({addr[XLEN-1:2], 2'b00} + data_t'(4)) : addr;
  assign data_we_o   = ex_we_i;

  // Rotate store data left by the byte offset, same in both phases
  assign wdata_pair   = {ex_wdata_i, ex_wdata_i} << {offset, 3'b000};
  assign data_wdata_o = wdata_pair[63:32];

  ////////////////////////////////////////////////////////////
  // Transfer attributes to the queue
  ////////////////////////////////////////////////////////////

  assign txn.push = gnt;

  always_comb begin
    txn.txn.size   = ex_size_i;
    txn.txn.sext   = ex_sext_i;
    txn.txn.we     = ex_we_i;
    txn.txn.offset = offset;
    txn.txn.last   = !first_of_split;
  end

endmodule

/* source/lsu_txn_queue.sv */
/*
  In-order queue of outstanding transfer attributes.
  Holds MAX_OUTSTANDING entries, valid values are 1 to 4.
  Responses must arrive in grant order, one per transfer, stores included.
  A response with nothing held pulses protocol_err_o and pops nothing.
*/

`timescale 1ns/100ps

module lsu_txn_queue #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              data_rvalid_i,
  input  logic              ex_valid_i,
  output lsu_pkg::lsu_txn_t head_o,
  output logic              pop_o,
  output logic              busy_o,
  output logic              protocol_err_o,
  lsu_txn_if.sink           txn
);

  import lsu_pkg::*;

  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  lsu_txn_t           mem [MAX_OUTSTANDING];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  // Fill count
  logic [CNT_W-1:0]   count_q;
  logic               empty;

  // Wrap at the entry count, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty    = (count_q == '0);
  assign txn.full = (count_q == CNT_W'(MAX_OUTSTANDING));

  // Oldest outstanding transfer
  assign head_o = mem[rd_ptr_q];

  assign pop_o          = data_rvalid_i && !empty;
  assign protocol_err_o = data_rvalid_i && empty;

  // Outstanding work or a pending request
  assign busy_o = !empty || ex_valid_i;

  ////////////////////////////////////////////////////////////
  // Pointers and fill count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (txn.push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_o) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Push and pop in one cycle leave the count alone
      case ({txn.push, pop_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (txn.push) begin
      mem[wr_ptr_q] <= txn.txn;
    end
  end

endmodule

/* source/lsu_rdata_align.sv */
/*
  Load data realignment and extension.
  Acts on the head entry of the transfer queue in its response cycle.
  A split load yields a single result, at its second response.
  Store responses produce no result.
*/

`timescale 1ns/100ps

module lsu_rdata_align (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pop_i,
  input  lsu_pkg::lsu_txn_t head_i,
  input  lsu_pkg::data_t    data_rdata_i,
  output logic              rdata_valid_o,
  output lsu_pkg::data_t    rdata_o
);

  import lsu_pkg::*;

  logic         load_pop;
  logic         first_half;
  logic [63:0]  rdata_full;
  logic [63:0]  rdata_aligned;

  // Raw word of the first half of a split load
  data_t        rdata_q;
  // rdata_q holds a first half that awaits its second
  logic         half_held_q;

  assign load_pop   = pop_i && !head_i.we;
  assign first_half = load_pop && !head_i.last;

  ////////////////////////////////////////////////////////////
  // First half capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_held_q <= 1'b0;
    end else if (first_half) begin
      half_held_q <= 1'b1;
    end else if (load_pop) begin
      half_held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (first_half) begin
      rdata_q <= data_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Join, realign and extend
  ////////////////////////////////////////////////////////////

  // Lower word is the earlier half when split
  assign rdata_full = half_held_q ? {data_rdata_i, rdata_q} : {data_rdata_i, data_rdata_i};

  // Byte at the access offset moves to lane 0
  assign rdata_aligned = rdata_full >> {head_i.offset, 3'b000};

  always_comb begin
    case (head_i.size)
      LSU_BYTE: rdata_o = {{24{head_i.sext & rdata_aligned[7]}}, rdata_aligned[7:0]};
      LSU_HALF: rdata_o = {{16{head_i.sext & rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:  rdata_o = rdata_aligned[31:0];
    endcase
  end

  // Result only on the last response of a load
  assign rdata_valid_o = load_pop && head_i.last;

endmodule

/* source/lsu_top.sv */
/*
  Load/store unit top level.
  Plain request/grant bus with in-order read-valid responses.
  Responses come at least one cycle after their grant, one per transfer.
  MAX_OUTSTANDING sets the number of transfers in flight, 1 to 4.
*/

`timescale 1ns/100ps

module lsu_top #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  // Execute stage
  input  logic               ex_valid_i,
  output logic               ex_ready_o,
  input  lsu_pkg::data_t     ex_operand_a_i,
  input  lsu_pkg::data_t     ex_operand_b_i,
  input  lsu_pkg::data_t     ex_wdata_i,
  input  logic               ex_we_i,
  input  logic               ex_sext_i,
  input  lsu_pkg::lsu_size_e ex_size_i,
  // Data bus
  output logic               data_req_o,
  input  logic               data_gnt_i,
  output logic               data_we_o,
  output lsu_pkg::data_t     data_addr_o,
  output lsu_pkg::be_t       data_be_o,
  output lsu_pkg::data_t     data_wdata_o,
  input  logic               data_rvalid_i,
  input  lsu_pkg::data_t     data_rdata_i,
  // Load result and status
  output logic               rdata_valid_o,
  output lsu_pkg::data_t     rdata_o,
  output logic               busy_o,
  output logic               protocol_err_o
);

  import lsu_pkg::*;

  lsu_txn_t  head;
  logic      pop;

  // Granted transfers into the queue
  lsu_txn_if txn_if ();

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  lsu_request_gen request_gen_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_i),
    .ex_ready_o     (ex_ready_o),
    .ex_operand_a_i (ex_operand_a_i),
    .ex_operand_b_i (ex_operand_b_i),
    .ex_wdata_i     (ex_wdata_i),
    .ex_we_i        (ex_we_i),
    .ex_sext_i      (ex_sext_i),
    .ex_size_i      (ex_size_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_we_o      (data_we_o),
    .data_addr_o    (data_addr_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .txn            (txn_if)
  );

  ////////////////////////////////////////////////////////////
  // Outstanding transfers and response side
  ////////////////////////////////////////////////////////////

  lsu_txn_queue #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) txn_queue_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_rvalid_i  (data_rvalid_i),
    .ex_valid_i     (ex_valid_i),
    .head_o         (head),
    .pop_o          (pop),
    .busy_o         (busy_o),
    .protocol_err_o (protocol_err_o),
    .txn            (txn_if)
  );

  lsu_rdata_align rdata_align_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pop_i         (pop),
    .head_i        (head),
    .data_rdata_i  (data_rdata_i),
    .rdata_valid_o (rdata_valid_o),
    .rdata_o       (rdata_o)
  );

endmodule

/* tests/lsu_assert.sv */
/*
  Bus and queue properties of the load/store unit, bound to its top level.
  fill_count_i is the fill count of the transfer queue.
*/

`timescale 1ns/100ps

module lsu_assert #(
  parameter int unsigned MAX_OUTSTANDING = 2,
  parameter int unsigned CNT_W           = $clog2(MAX_OUTSTANDING + 1)
) (
  input logic             clk,
  input logic             rst_n,
  input logic             ex_valid_i,
  input logic             req_i,
  input logic             gnt_i,
  input logic             we_i,
  input lsu_pkg::data_t   addr_i,
  input lsu_pkg::data_t   wdata_i,
  input lsu_pkg::be_t     be_i,
  input logic [CNT_W-1:0] fill_count_i
);

  // Ungranted request keeps its fields while the access is still offered
  property req_held_p;
    @(posedge clk) disable iff (!rst_n)
      (req_i && !gnt_i) |=> (!ex_valid_i || (req_i && $stable(addr_i) && $stable(we_i) &&
                                             $stable(be_i) && $stable(wdata_i)));
  endproperty

  req_held_a: assert property (req_held_p)
    else $error("bus request dropped or changed before its grant");

  // Never more entries than the queue can hold
  fill_limit_a: assert property (@(posedge clk) disable iff (!rst_n)
                                 fill_count_i <= CNT_W'(MAX_OUTSTANDING))
    else $error("transfer queue holds more than MAX_OUTSTANDING entries");

endmodule

bind lsu_top lsu_assert #(
  .MAX_OUTSTANDING (MAX_OUTSTANDING)
) lsu_assert_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .ex_valid_i   (ex_valid_i),
  .req_i        (data_req_o),
  .gnt_i        (data_gnt_i),
  .we_i         (data_we_o),
  .addr_i       (data_addr_o),
  .wdata_i      (data_wdata_o),
  .be_i         (data_be_o),
  .fill_count_i (txn_queue_inst.count_q)
);

/* tests/lsu_tb.sv */
/*
  Random testbench of the load/store unit with a bus memory model.
  Accesses stay in a 256-byte window, a split at the top wraps to address 0.
  Grants come after 0 to 2 cycles, responses in order after 1 to 3 cycles.
*/

`timescale 1ns/100ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int MAX_OUT  = 2;
  localparam int N_ACCESS = 400;
  localparam int TIMEOUT  = N_ACCESS * 20 + 200;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      ex_valid_i, ex_ready_o, ex_we_i, ex_sext_i;
  data_t     ex_operand_a_i, ex_operand_b_i, ex_wdata_i;
  lsu_size_e ex_size_i;
  logic      data_req_o, data_gnt_i, data_we_o, data_rvalid_i;
  data_t     data_addr_o, data_wdata_o, data_rdata_i;
  be_t       data_be_o;
  logic      rdata_valid_o, busy_o, protocol_err_o;
  data_t     rdata_o;

  // Bus memory and reference memory
  logic [7:0] bus_mem [256];
  logic [7:0] ref_mem [256];

  // Predicted transfers and load results, oldest first
  data_t exp_addr_q [$];
  be_t   exp_be_q [$];
  data_t exp_wdata_q [$];
  logic  exp_we_q [$];
  data_t exp_rdata_q [$];
  // Pending bus responses
  data_t resp_data_q [$];
  int    resp_due_q [$];

  int   value_errs = 0;
  int   other_errs = 0;
  int   cycle_cnt = 0;
  int   outstanding;
  logic spurious_req;
  logic spurious_sent;

  lsu_top #(.MAX_OUTSTANDING(MAX_OUT)) lsu_top_inst (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("ERROR: timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERROR at %0t: %s is %08h, expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_be(input string name, input be_t got, input be_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERROR at %0t: %s is %04b, expected %04b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////////////////////////

  task automatic accept_transfer(input int now);
    logic [7:0] base;
    data_t      word;
    logic       exp_we;
    data_t      exp_wdata;
    base = {data_addr_o[7:2], 2'b00};
    if (exp_addr_q.size() == 0) begin
      other_errs++;
      $display("ERROR at %0t: bus transfer granted with no access pending", $time);
    end else begin
      exp_we    = exp_we_q.pop_front();
      exp_wdata = exp_wdata_q.pop_front();
      check_data("data_addr_o", data_addr_o, exp_addr_q.pop_front());
      check_be("data_be_o", data_be_o, exp_be_q.pop_front());
      check_flag("data_we_o", data_we_o, exp_we);
      if (exp_we) begin
        check_data("data_wdata_o", data_wdata_o, exp_wdata);
      end
    end
    // Only enabled lanes are written
    for (int i = 0; i < 4; i++) begin
      if (data_we_o && data_be_o[i]) begin
        bus_mem[8'(base + i)] = data_wdata_o[8*i +: 8];
      end
      word[8*i +: 8] = bus_mem[8'(base + i)];
    end
    resp_data_q.push_back(word);
    resp_due_q.push_back(now + int'($urandom_range(3, 1)));
  endtask

  initial begin : bus_model
    int bus_cyc;
    int gnt_wait;
    bus_cyc       = 0;
    gnt_wait      = 0;
    outstanding   = 0;
    spurious_sent = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    forever begin
      @(posedge clk);
      bus_cyc++;
      // Busy while a transfer is in flight or an access is offered
      if (rst_n) begin
        check_flag("busy_o", busy_o, (outstanding != 0) || ex_valid_i);
      end
      if (data_rvalid_i && !spurious_sent) begin
        outstanding--;
      end
      if (data_req_o && data_gnt_i) begin
        accept_transfer(bus_cyc);
        outstanding++;
        gnt_wait = int'($urandom_range(2, 0));
      end
      if (outstanding > MAX_OUT) begin
        other_errs++;
        $display("ERROR at %0t: %0d transfers in flight, more than allowed", $time, outstanding);
      end
      @(negedge clk);
      data_gnt_i = (gnt_wait == 0);
      if (gnt_wait > 0) begin
        gnt_wait--;
      end
      data_rvalid_i = 1'b0;
      spurious_sent = 1'b0;
      // Earliest response one cycle after its grant
      if (resp_due_q.size() != 0 && resp_due_q[0] <= bus_cyc + 1) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = resp_data_q.pop_front();
        void'(resp_due_q.pop_front());
      end else if (spurious_req) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = $urandom;
        spurious_sent = 1'b1;
      end
    end
  end

  // Load results in issue order
  always @(posedge clk) begin
    if (rst_n && rdata_valid_o) begin
      if (exp_rdata_q.size() == 0) begin
        other_errs++;
        $display("ERROR at %0t: load result with no load pending", $time);
      end else begin
        check_data("rdata_o", rdata_o, exp_rdata_q.pop_front());
      end
    end
    if (rst_n && protocol_err_o && !spurious_sent) begin
      other_errs++;
      $display("ERROR at %0t: protocol_err_o raised on a regular response", $time);
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////////////////////////

  task automatic run_access(input data_t addr, input lsu_size_e size, input logic we,
                            input logic sext, input data_t wdata);
    int         nbytes;
    be_t        be_first;
    be_t        be_second;
    data_t      rot;
    data_t      value;
    logic [7:0] b;
    @(negedge clk);
    nbytes    = (size == LSU_BYTE) ? 1 : ((size == LSU_HALF) ? 2 : 4);
    be_first  = '0;
    be_second = '0;
    value     = '0;
    for (int j = 0; j < nbytes; j++) begin
      // Bytes past the end of the first word go to the second transfer
      if (int'(addr[1:0]) + j < 4) begin
        be_first[int'(addr[1:0]) + j] = 1'b1;
      end else begin
        be_second[int'(addr[1:0]) + j - 4] = 1'b1;
      end
      b = 8'(addr + data_t'(j));
      value[8*j +: 8] = ref_mem[b];
      if (we) begin
        ref_mem[b] = wdata[8*j +: 8];
      end
    end
    // Byte j of the store data sits in lane j plus offset
    for (int l = 0; l < 4; l++) begin
      rot[8*l +: 8] = wdata[8*((l - int'(addr[1:0])) & 3) +: 8];
    end
    if (sext && size == LSU_BYTE) value[31:8] = {24{value[7]}};
    if (sext && size == LSU_HALF) value[31:16] = {16{value[15]}};
    exp_addr_q.push_back(addr);
    exp_be_q.push_back(be_first);
    exp_we_q.push_back(we);
    exp_wdata_q.push_back(rot);
    if (be_second != '0) begin
      exp_addr_q.push_back({addr[31:2], 2'b00} + 32'd4);
      exp_be_q.push_back(be_second);
      exp_we_q.push_back(we);
      exp_wdata_q.push_back(rot);
    end
    if (!we) exp_rdata_q.push_back(value);
    ex_valid_i     = 1'b1;
    ex_operand_a_i = $urandom;
    ex_operand_b_i = addr - ex_operand_a_i;
    ex_size_i      = size;
    ex_we_i        = we;
    ex_sext_i      = sext;
    ex_wdata_i     = wdata;
    // Inputs held until the access is taken
    @(posedge clk);
    while (ex_ready_o !== 1'b1) @(posedge clk);
  endtask

  initial begin
    void'($urandom(32'h7f03c74a));
    rst_n          = 1'b0;
    spurious_req   = 1'b0;
    ex_valid_i     = 1'b0;
    ex_operand_a_i = '0;
    ex_operand_b_i = '0;
    ex_wdata_i     = '0;
    ex_we_i        = 1'b0;
    ex_sext_i      = 1'b0;
    ex_size_i      = LSU_WORD;
    for (int i = 0; i < 256; i++) begin
      bus_mem[i] = 8'(i * 37 + 11);
      ref_mem[i] = bus_mem[i];
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < N_ACCESS; n++) begin
      if ($urandom_range(7, 0) == 0) begin
        @(negedge clk);
        ex_valid_i = 1'b0;
      end
      run_access(data_t'($urandom_range(255, 0)), lsu_size_e'($urandom_range(2, 0)),
                 1'($urandom), 1'($urandom), $urandom);
    end
    @(negedge clk);
    ex_valid_i = 1'b0;
    // Drain every response before looking at busy
    while (exp_rdata_q.size() != 0 || resp_due_q.size() != 0 || outstanding != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    check_flag("busy_o", busy_o, 1'b0);
    if (exp_addr_q.size() != 0) begin
      other_errs++;
      $display("ERROR: %0d predicted transfers were never issued", exp_addr_q.size());
    end
    // Response with nothing outstanding
    spurious_req = 1'b1;
    @(posedge clk);
    if (protocol_err_o !== 1'b1) begin
      other_errs++;
      $display("ERROR at %0t: protocol_err_o did not pulse on a stray response", $time);
    end
    spurious_req = 1'b0;
    @(posedge clk);
    check_flag("protocol_err_o", protocol_err_o, 1'b0);
    $display("%0d accesses: %0d value errors, %0d other errors",
             N_ACCESS, value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/lsu_pkg.sv
source/lsu_txn_if.sv
source/lsu_request_gen.sv
source/lsu_txn_queue.sv
source/lsu_rdata_align.sv
source/lsu_top.sv
tests/lsu_assert.sv
tests/lsu_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/100ps
TOP       := lsu_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
